// ==== source/lenet_geom_pkg.sv ====
`default_nettype none

package lenet_geom_pkg;

    // ******************************
    // Data widths
    // ******************************

    // Pixels, weights and output features share one width.
    localparam int PIXEL_W = 8;
    localparam int PROD_W = 16;

    // ******************************
    // Kernel geometry
    // ******************************

    // A 5x5 window, serialized row by row.
    localparam int KERNEL_TAPS = 25;
    localparam int TAP_IDX_W = 5;

    // 25 products of at most 16 bits each need 21 bits.
    localparam int ACC_W = 21;

    // ******************************
    // Requantization
    // ******************************

    localparam int QUANT_SHIFT = 8;
    localparam int FEAT_MAX = 255;

endpackage

`default_nettype wire

// ==== source/conv_ctrl_pkg.sv ====
`default_nettype none

package conv_ctrl_pkg;
    import lenet_geom_pkg::*;

    // Unsigned pixel, weight or feature value.
    typedef logic [PIXEL_W-1:0] pixel_t;

    // One kernel write. The tap index sits in the upper bits.
    typedef struct packed {
        logic [TAP_IDX_W-1:0] tap;
        pixel_t               value;
    } weight_load_t;

    // IDLE waits for the first tap of a window, ACCUM for the rest.
    // HOLD keeps the finished sum until the output stage takes it.
    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        HOLD
    } mac_state_t;

endpackage

`default_nettype wire

// ==== source/approx_mult_8x8.sv ====
`default_nettype none

module approx_mult_8x8 import conv_ctrl_pkg::*; (
    input  pixel_t      x,
    input  pixel_t      y,
    output logic [15:0] z
);

    logic [7:0]  row [8];
    logic [12:0] cv [6];

    // ******************************
    // Partial product rows
    // ******************************

    always_comb begin
        for (int i = 0; i < 8; i++) begin
            row[i] = y & {8{x[i]}};
        end
    end

    // ******************************
    // Compression table
    // ******************************

    // Rows 0 to 5 are folded into six sparse vectors. Most bit positions
    // stay zero, which is where the saving in the adder tree comes from.
    always_comb begin
        cv[0] = '0;
        cv[1] = '0;
        cv[2] = '0;
        cv[3] = '0;
        cv[4] = '0;
        cv[5] = '0;

        cv[0][1] = row[0][1] | row[1][0];
        cv[0][2] = row[0][1] & row[1][0];
        cv[0][4] = row[2][2] & row[3][1];
        cv[0][7] = row[0][6] | row[1][5];
        cv[0][8] = row[1][7];
        cv[0][9] = row[2][6] & row[3][5];
        cv[0][10] = row[2][7] & row[3][6];
        cv[0][11] = row[4][7] ^ row[5][6];
        cv[0][12] = row[4][7] & row[5][6];

        cv[1][4] = row[4][0];
        cv[1][7] = row[0][7] | row[1][6];
        cv[1][8] = row[2][6] ^ row[3][5];
        cv[1][9] = row[2][7] ^ row[3][6];
        cv[1][10] = row[3][7];
        cv[1][12] = row[5][7];

        cv[2][7] = row[2][4] | row[3][3];
        cv[2][8] = row[4][3] | row[5][2];
        cv[2][9] = row[4][5] & row[5][4];
        cv[2][10] = row[4][6] & row[5][5];

        cv[3][7] = row[2][5] ^ row[3][4];
        cv[3][8] = row[4][4] | row[5][3];
        cv[3][9] = row[4][5] | row[5][4];
        cv[3][10] = row[4][6] | row[5][5];

        cv[4][7] = row[4][2] & row[5][1];

        cv[5][7] = row[4][3] & row[5][2];
    end

    // ******************************
    // Final sum
    // ******************************

    // The two top rows carry most of the weight and are added exactly.
    assign z = 16'({row[6], 6'b0})
             + 16'({row[7], 7'b0})
             + 16'(cv[0])
             + 16'(cv[1])
             + 16'(cv[2])
             + 16'(cv[3])
             + 16'(cv[4])
             + 16'(cv[5]);

endmodule

`default_nettype wire

// ==== source/four_phase_rx.sv ====
`default_nettype none

module four_phase_rx import conv_ctrl_pkg::*; #(
    parameter type payload_t = pixel_t
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic req,
    input  payload_t  data,
    input  wire logic ready,
    output logic      ack,
    output logic      valid,
    output payload_t  payload
);

    logic accept;

    // A new transfer starts only from the idle phase of the handshake.
    assign accept = req && !ack && ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
            valid <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (accept) begin
                ack <= 1'b1;
                valid <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            payload <= data;
        end
    end

    // The sender must hold its data until the transfer is acknowledged.
    a_data_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (req && !ack) |=> $stable(data)
    ) else $error("four_phase_rx: data changed before ack");

endmodule

`default_nettype wire

// ==== source/kernel_store.sv ====
`default_nettype none

module kernel_store import lenet_geom_pkg::*, conv_ctrl_pkg::*; (
    input  wire logic                 clk,
    input  wire logic                 rst_n,
    input  wire logic                 wr_valid,
    input  weight_load_t              wr_entry,
    input  wire logic [TAP_IDX_W-1:0] tap,
    output pixel_t                    weight,
    output logic                      loaded
);

    pixel_t                 weights [KERNEL_TAPS];
    logic [KERNEL_TAPS-1:0] written;

    // ******************************
    // Weight registers
    // ******************************

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            weights[wr_entry.tap] <= wr_entry.value;
        end
    end

    // One bit per tap. Rewrites between windows leave the mask full.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            written <= '0;
        end else if (wr_valid) begin
            written[wr_entry.tap] <= 1'b1;
        end
    end

    // ******************************
    // Read side
    // ******************************

    assign weight = weights[tap];
    assign loaded = &written;

    // A write beyond the last tap would be lost and loaded would never rise.
    a_tap_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        wr_valid |-> (wr_entry.tap < KERNEL_TAPS)
    ) else $error("kernel_store: write to tap %0d", wr_entry.tap);

endmodule

`default_nettype wire

// ==== source/conv_mac.sv ====
`default_nettype none

module conv_mac import lenet_geom_pkg::*, conv_ctrl_pkg::*; (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  pix_valid,
    input  pixel_t                     pix,
    input  wire logic                  kernel_ready,
    input  pixel_t                     weight,
    output logic [TAP_IDX_W-1:0]       tap,
    output logic                       pix_ready,
    output logic [ACC_W-1:0]           sum,
    output logic                       sum_valid,
    input  wire logic                  sum_taken
);

    mac_state_t        state;
    logic [PROD_W-1:0] product;
    logic              last_tap;

    // The weight drives x, so weights limited to bits 6 and 7 give exact products.
    approx_mult_8x8 mult_inst (
        .x (weight),
        .y (pix),
        .z (product)
    );

    assign last_tap = (tap == TAP_IDX_W'(KERNEL_TAPS - 1));

    // No pixel is taken before the kernel is complete or while a sum waits.
    assign pix_ready = kernel_ready && (state != HOLD);
    assign sum_valid = (state == HOLD);

    // ******************************
    // Controller and tap counter
    // ******************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            tap <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pix_valid) begin
                        state <= ACCUM;
                        tap <= tap + 1'b1;
                    end
                end
                ACCUM: begin
                    if (pix_valid) begin
                        if (last_tap) begin
                            state <= HOLD;
                            tap <= '0;
                        end else begin
                            tap <= tap + 1'b1;
                        end
                    end
                end
                HOLD: begin
                    if (sum_taken) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // ******************************
    // Accumulator
    // ******************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sum <= '0;
        end else if (state == HOLD) begin
            if (sum_taken) begin
                sum <= '0;
            end
        end else if (pix_valid) begin
            sum <= sum + ACC_W'(product);
        end
    end

    // A pixel that arrived while the sum waits would be dropped by the accumulator.
    a_no_pixel_in_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        sum_valid |-> !pix_valid
    ) else $error("conv_mac: pixel arrived while a sum was held");

endmodule

`default_nettype wire

// ==== source/requant_out.sv ====
`default_nettype none

module requant_out import lenet_geom_pkg::*, conv_ctrl_pkg::*; (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic [ACC_W-1:0] sum,
    input  wire logic             sum_valid,
    output logic                  sum_taken,
    output logic                  feat_req,
    output pixel_t                feat_data,
    input  wire logic             feat_ack
);

    logic [ACC_W-QUANT_SHIFT-1:0] shifted;
    pixel_t                       feat;
    logic                         ack_wait;
    logic                         start;

    assign shifted = sum[ACC_W-1:QUANT_SHIFT];
    assign feat = (shifted > FEAT_MAX) ? pixel_t'(FEAT_MAX) : shifted[PIXEL_W-1:0];

    // A new sum is taken only when both handshake lines are back at rest.
    assign start = sum_valid && !feat_req && !ack_wait;
    assign sum_taken = feat_req && feat_ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            feat_req <= 1'b0;
            ack_wait <= 1'b0;
        end else if (sum_taken) begin
            feat_req <= 1'b0;
            ack_wait <= 1'b1;
        end else if (ack_wait && !feat_ack) begin
            ack_wait <= 1'b0;
        end else if (start) begin
            feat_req <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            feat_data <= feat;
        end
    end

endmodule

`default_nettype wire

// ==== source/conv5x5_unit.sv ====
`default_nettype none

module conv5x5_unit import lenet_geom_pkg::*, conv_ctrl_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic pix_req,
    input  pixel_t    pix_data,
    output logic      pix_ack,
    input  wire logic wt_req,
    input  weight_load_t wt_data,
    output logic      wt_ack,
    output logic      feat_req,
    output pixel_t    feat_data,
    input  wire logic feat_ack
);

    logic                 pix_valid;
    pixel_t               pix;
    logic                 pix_ready;
    logic                 wt_valid;
    weight_load_t         wt_entry;
    logic [TAP_IDX_W-1:0] tap;
    pixel_t               weight;
    logic                 loaded;
    logic [ACC_W-1:0]     sum;
    logic                 sum_valid;
    logic                 sum_taken;

    // ******************************
    // Input channels
    // ******************************

    four_phase_rx #(.payload_t(pixel_t)) pix_rx_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (pix_req),
        .data    (pix_data),
        .ready   (pix_ready),
        .ack     (pix_ack),
        .valid   (pix_valid),
        .payload (pix)
    );

    // Weight writes are always accepted.
    four_phase_rx #(.payload_t(weight_load_t)) wt_rx_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (wt_req),
        .data    (wt_data),
        .ready   (1'b1),
        .ack     (wt_ack),
        .valid   (wt_valid),
        .payload (wt_entry)
    );

    // ******************************
    // Datapath
    // ******************************

    kernel_store kernel_store_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (wt_valid),
        .wr_entry (wt_entry),
        .tap      (tap),
        .weight   (weight),
        .loaded   (loaded)
    );

    conv_mac conv_mac_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .pix          (pix),
        .kernel_ready (loaded),
        .weight       (weight),
        .tap          (tap),
        .pix_ready    (pix_ready),
        .sum          (sum),
        .sum_valid    (sum_valid),
        .sum_taken    (sum_taken)
    );

    requant_out requant_out_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .sum       (sum),
        .sum_valid (sum_valid),
        .sum_taken (sum_taken),
        .feat_req  (feat_req),
        .feat_data (feat_data),
        .feat_ack  (feat_ack)
    );

endmodule

`default_nettype wire

// ==== tb/conv_ref_tasks.svh ====
`ifndef CONV_REF_TASKS_SVH
`define CONV_REF_TASKS_SVH

// ******************************
// Reference model
// ******************************

// Weight on x, pixel on y. Rows 6 and 7 keep their full value, the low rows
// only reach the result through the sparse terms grouped here by bit weight.
function automatic int unsigned approx_product(input pixel_t x, input pixel_t y);
    logic [7:0]  r [8];
    int unsigned acc;
    for (int i = 0; i < 8; i++) begin
        r[i] = x[i] ? y : 8'h00;
    end
    acc = (32'(r[6]) << 6) + (32'(r[7]) << 7);
    acc += 32'(r[0][1] | r[1][0]) << 1;
    acc += 32'(r[0][1] & r[1][0]) << 2;
    acc += (32'(r[2][2] & r[3][1]) + 32'(r[4][0])) << 4;
    acc += (32'(r[0][6] | r[1][5]) + 32'(r[0][7] | r[1][6]) + 32'(r[2][4] | r[3][3])
          + 32'(r[2][5] ^ r[3][4]) + 32'(r[4][2] & r[5][1]) + 32'(r[4][3] & r[5][2])) << 7;
    acc += (32'(r[1][7]) + 32'(r[2][6] ^ r[3][5]) + 32'(r[4][3] | r[5][2])
          + 32'(r[4][4] | r[5][3])) << 8;
    acc += (32'(r[2][6] & r[3][5]) + 32'(r[2][7] ^ r[3][6]) + 32'(r[4][5] & r[5][4])
          + 32'(r[4][5] | r[5][4])) << 9;
    acc += (32'(r[2][7] & r[3][6]) + 32'(r[3][7]) + 32'(r[4][6] & r[5][5])
          + 32'(r[4][6] | r[5][5])) << 10;
    acc += 32'(r[4][7] ^ r[5][6]) << 11;
    acc += (32'(r[4][7] & r[5][6]) + 32'(r[5][7])) << 12;
    return acc;
endfunction

function automatic int unsigned window_sum();
    int unsigned total;
    total = 0;
    for (int i = 0; i < KERNEL_TAPS; i++) begin
        total += approx_product(kernel[i], window[i]);
    end
    return total;
endfunction

// Exact dot product, used where every weight is a multiple of 64.
function automatic int unsigned exact_sum();
    int unsigned total;
    total = 0;
    for (int i = 0; i < KERNEL_TAPS; i++) begin
        total += int'(kernel[i]) * int'(window[i]);
    end
    return total;
endfunction

function automatic pixel_t requant(input int unsigned sum);
    int unsigned shifted;
    shifted = sum >> QUANT_SHIFT;
    return (shifted > FEAT_MAX) ? pixel_t'(FEAT_MAX) : pixel_t'(shifted);
endfunction

// ******************************
// Compare tasks
// ******************************

task automatic check_pixel(input string name, input pixel_t got, input pixel_t expected);
    if (got !== expected) begin
        $display("FAILED at time %0t: %s is %0d, expected %0d", $time, name, got, expected);
        stop_run();
    end
endtask

task automatic check_line(input string name, input logic got, input logic expected);
    if (got !== expected) begin
        $display("FAILED at time %0t: %s is %b, expected %b", $time, name, got, expected);
        stop_run();
    end
endtask

`endif

// ==== tb/tb_conv5x5_unit.sv ====
`default_nettype none

module tb_conv5x5_unit import lenet_geom_pkg::*, conv_ctrl_pkg::*;;

    localparam int NUM_WINDOWS = 14;
    localparam int NUM_WT_WRITES = 106;
    localparam int NUM_HANDSHAKES = NUM_WINDOWS * (KERNEL_TAPS + 1) + NUM_WT_WRITES;
    localparam int TIMEOUT_CYCLES = 40 * NUM_HANDSHAKES + 2000;

    // The eleventh feature opens the back-pressure pair and is acked late.
    localparam int HELD_FEATURE = 10;
    localparam int HOLD_CYCLES = 300;

    logic         clk;
    logic         rst_n;
    logic         pix_req;
    pixel_t       pix_data;
    logic         pix_ack;
    logic         wt_req;
    weight_load_t wt_data;
    logic         wt_ack;
    logic         feat_req;
    pixel_t       feat_data;
    logic         feat_ack;

    integer                 seed = 32'h7274_90ee;
    pixel_t                 kernel [KERNEL_TAPS];
    pixel_t                 window [KERNEL_TAPS];
    pixel_t                 expected_q [$];
    int                     features_done = 0;
    int                     cycle_count = 0;
    int                     pixels_taken = 0;
    int                     sums_taken = 0;
    logic [KERNEL_TAPS-1:0] written_mask = '0;
    logic                   pix_ack_prev = 1'b0;
    logic                   wt_ack_prev = 1'b0;

    conv5x5_unit conv5x5_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_req   (pix_req),
        .pix_data  (pix_data),
        .pix_ack   (pix_ack),
        .wt_req    (wt_req),
        .wt_data   (wt_data),
        .wt_ack    (wt_ack),
        .feat_req  (feat_req),
        .feat_data (feat_data),
        .feat_ack  (feat_ack)
    );

    always #20 clk = ~clk;

    task automatic stop_run();
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "conv_ref_tasks.svh"

    function automatic pixel_t random_byte();
        return pixel_t'($random(seed));
    endfunction

    // ******************************
    // Senders
    // ******************************

    task automatic send_pixel(input pixel_t value);
        @(posedge clk);
        pix_data <= value;
        pix_req <= 1'b1;
        @(posedge clk);
        while (!pix_ack) begin
            @(posedge clk);
        end
        pix_req <= 1'b0;
        @(posedge clk);
        while (pix_ack) begin
            @(posedge clk);
        end
    endtask

    task automatic send_weight(input int tap, input pixel_t value);
        weight_load_t entry;
        entry.tap = TAP_IDX_W'(tap);
        entry.value = value;
        @(posedge clk);
        wt_data <= entry;
        wt_req <= 1'b1;
        @(posedge clk);
        while (!wt_ack) begin
            @(posedge clk);
        end
        wt_req <= 1'b0;
        @(posedge clk);
        while (wt_ack) begin
            @(posedge clk);
        end
    endtask

    // Writes count taps in shuffled order. With fresh set, those taps get new values.
    task automatic write_taps(input int count, input bit fresh);
        int order [KERNEL_TAPS];
        int j;
        int tmp;
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            order[i] = i;
        end
        for (int i = KERNEL_TAPS - 1; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int k = 0; k < count; k++) begin
            if (fresh) begin
                kernel[order[k]] = random_byte();
            end
            send_weight(order[k], kernel[order[k]]);
        end
    endtask

    task automatic send_window(input pixel_t expected);
        expected_q.push_back(expected);
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            send_pixel(window[i]);
        end
    endtask

    task automatic fill_window(input int shift);
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            window[i] = random_byte() >> shift;
        end
    endtask

    // While the first feature is withheld, no pixel of the next window may get through.
    task automatic watch_stall();
        @(posedge clk);
        while (!feat_req) begin
            @(posedge clk);
        end
        while (!feat_ack) begin
            check_line("pix_ack", pix_ack, 1'b0);
            @(posedge clk);
        end
    endtask

    // ******************************
    // Feature receiver and monitors
    // ******************************

    always begin : feature_receiver
        int delay;
        @(posedge clk);
        if (rst_n && feat_req && !feat_ack) begin
            if (expected_q.size() == 0) begin
                $display("A feature arrived while no window was pending.");
                stop_run();
            end
            check_pixel("feat_data", feat_data, expected_q.pop_front());
            delay = (features_done == HELD_FEATURE) ? HOLD_CYCLES
                                                    : ($unsigned($random(seed)) % 4);
            repeat (delay) @(posedge clk);
            feat_ack <= 1'b1;
            @(posedge clk);
            while (feat_req) begin
                @(posedge clk);
            end
            feat_ack <= 1'b0;
            features_done++;
        end
    end

    always @(posedge clk) begin : handshake_monitor
        if (rst_n) begin
            if (wt_ack && !wt_ack_prev) begin
                written_mask[wt_data.tap] = 1'b1;
            end
            if (feat_req && feat_ack) begin
                sums_taken++;
            end
            if (pix_ack && !pix_ack_prev) begin
                pixels_taken++;
                if (written_mask != '1) begin
                    $display("A pixel was acked before every kernel tap had been written.");
                    stop_run();
                end
                if (pixels_taken > KERNEL_TAPS * (sums_taken + 1)) begin
                    $display("A pixel was acked while a finished sum still waited for output.");
                    stop_run();
                end
            end
        end
        pix_ack_prev = pix_ack;
        wt_ack_prev = wt_ack;
    end

    always @(posedge clk) begin : cycle_limit
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("The run did not finish within %0d cycles.", TIMEOUT_CYCLES);
            stop_run();
        end
    end

    // ******************************
    // Test sequence
    // ******************************

    initial begin : test_sequence
        clk = 1'b0;
        rst_n = 1'b0;
        pix_req = 1'b0;
        pix_data = '0;
        wt_req = 1'b0;
        wt_data = '0;
        feat_ack = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_line("pix_ack", pix_ack, 1'b0);
        check_line("wt_ack", wt_ack, 1'b0);
        check_line("feat_req", feat_req, 1'b0);

        // Weights of 0x40, 0x80 or 0xC0 keep every product exact. The kernel
        // goes in shuffled while the first window already waits.
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            kernel[i] = pixel_t'((($unsigned($random(seed)) % 3) + 1) * 64);
        end
        fill_window(4);
        fork
            write_taps(KERNEL_TAPS, 1'b0);
            send_window(requant(exact_sum()));
        join
        fill_window(4);
        send_window(requant(exact_sum()));
        window = '{default: 8'hFF};
        send_window(requant(exact_sum()));

        // Zero pixels, then a zero kernel.
        window = '{default: 8'h00};
        send_window(8'd0);
        kernel = '{default: 8'h00};
        write_taps(KERNEL_TAPS, 1'b0);
        fill_window(0);
        send_window(8'd0);

        // Full scale on both sides saturates.
        kernel = '{default: 8'hFF};
        write_taps(KERNEL_TAPS, 1'b0);
        window = '{default: 8'hFF};
        send_window(8'd255);

        // Random kernel and windows through the approximate products.
        for (int i = 0; i < KERNEL_TAPS; i++) begin
            kernel[i] = random_byte() >> 2;
        end
        write_taps(KERNEL_TAPS, 1'b0);
        repeat (4) begin
            fill_window(2);
            send_window(requant(window_sum()));
        end

        // The first feature of this pair is held for a long time.
        fill_window(2);
        send_window(requant(window_sum()));
        fill_window(2);
        fork
            send_window(requant(window_sum()));
            watch_stall();
        join

        // Kernel reload of a few taps with full-range values.
        write_taps(6, 1'b1);
        repeat (2) begin
            fill_window(2);
            send_window(requant(window_sum()));
        end

        while (features_done < NUM_WINDOWS) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        check_line("pix_ack", pix_ack, 1'b0);
        check_line("wt_ack", wt_ack, 1'b0);
        check_line("feat_req", feat_req, 1'b0);
        if (expected_q.size() != 0) begin
            $display("Expected features were left over at the end of the run.");
            stop_run();
        end
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+tb
source/lenet_geom_pkg.sv
source/conv_ctrl_pkg.sv
source/approx_mult_8x8.sv
source/four_phase_rx.sv
source/kernel_store.sv
source/conv_mac.sv
source/requant_out.sv
source/conv5x5_unit.sv
tb/tb_conv5x5_unit.sv
